// File: alu.sv
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::ctrl_t  ctrl,
  input  isa_pkg::instr_t instruction,
  input  isa_pkg::word_t  rs_data,
  input  isa_pkg::word_t  rt_data,
  input  isa_pkg::word_t  imm,
  output isa_pkg::word_t  alu_result,
  output logic            equal
);
  import isa_pkg::*;
  import cpu_pkg::*;

  word_t a, b;

  assign a = rs_data;
  assign b = ctrl.alu_src_imm ? imm : rt_data; // operand b mux

  // branch compare is always register to register
  assign equal = (rs_data == rt_data);

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = a + b;  // addu/addiu, also lw/sw address
      ALU_SUB:  alu_result = a - b;
      ALU_AND:  alu_result = a & b;
      ALU_OR:   alu_result = a | b;
      ALU_XOR:  alu_result = a ^ b;
      ALU_SLT:  alu_result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: alu_result = {31'b0, a < b};
      ALU_SLL:  alu_result = b << instruction.shamt; // shifts act on rt
      ALU_SRL:  alu_result = b >> instruction.shamt; // logical, zero fill
      ALU_LUI:  alu_result = {b[15:0], 16'h0000};
      default:  alu_result = '0;
    endcase
  end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  // widths
  localparam int STATE_W  = 3;
  localparam int ALU_OP_W = 4;
  localparam int BE_W     = 4; // byte lanes on the avalon data bus
  localparam int ADDR_LSB = 2; // word aligned data address

  // boot address, top level passes it down to the pc
  parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000;

  // one instruction walks fetch -> load -> mem -> exec
  typedef enum logic [STATE_W-1:0] {
    FETCH  = 3'd0, // idle cycle before the instruction read
    LOAD   = 3'd1, // instruction read on the bus
    MEM    = 3'd2, // data read/write, or a single idle cycle
    EXEC   = 3'd3, // register write back and pc update
    HALTED = 3'd4  // left only by reset
  } state_t;

  typedef enum logic [ALU_OP_W-1:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_t;

  // decoded control word
  typedef struct packed {
    alu_op_t alu_op;
    logic    alu_src_imm;  // operand b is imm instead of rt
    logic    imm_zero_ext; // andi/ori/xori
    logic    reg_write;
    logic    dest_is_rd;   // r-type writes rd, i-type writes rt
    logic    mem_to_reg;   // write back load data
    logic    mem_read;
    logic    mem_write;
    logic    branch;
    logic    branch_ne;    // bne, else beq
    logic    jump;
    logic    jump_reg;
  } ctrl_t;

endpackage

// File: cpu_sequencer.sv
`timescale 1ns/100ps

module cpu_sequencer (
  input  logic             clk,
  input  logic             reset,
  input  logic             waitrequest,
  input  isa_pkg::word_t   readdata,
  input  isa_pkg::word_t   pc,
  input  isa_pkg::word_t   alu_result,
  input  cpu_pkg::ctrl_t   ctrl,
  output cpu_pkg::state_t  state,
  output isa_pkg::instr_t  instruction,
  output isa_pkg::word_t   load_data,
  output isa_pkg::word_t   address,
  output logic             read,
  output logic             write,
  output logic             active
);
  import isa_pkg::*;
  import cpu_pkg::*;

  logic  data_xfer; // this instruction touches data memory
  logic  xfer_done; // bus accepted the current transfer
  word_t data_addr;

  assign data_xfer = ctrl.mem_read | ctrl.mem_write;
  assign xfer_done = ~waitrequest;

  // low address bits dropped, lw/sw are word only
  assign data_addr = {alu_result[31:ADDR_LSB], {ADDR_LSB{1'b0}}};

  // pc during fetch/load, data address in mem
  assign address = (state == MEM) ? data_addr : pc;

  // strobes come straight from the state, so they hold while waitrequest is high
  assign read  = (state == LOAD) | ((state == MEM) & ctrl.mem_read);
  assign write = (state == MEM) & ctrl.mem_write;

  // control state
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= FETCH;
      active <= 1'b1;
    end else begin
      case (state)
        FETCH: state <= LOAD;
        LOAD: begin
          if (xfer_done) state <= MEM;
        end
        MEM: begin
          // non-memory instructions pass through in one cycle
          if (!data_xfer || xfer_done) state <= EXEC;
        end
        EXEC: begin
          if (pc == '0) begin // instruction at address 0 ends the run
            state  <= HALTED;
            active <= 1'b0;
          end else begin
            state <= FETCH;
          end
        end
        HALTED: state <= HALTED;
        default: state <= HALTED; // illegal encoding parks the cpu
      endcase
    end
  end

  // instruction and load data registers, captured on a completed read
  always_ff @(posedge clk) begin
    if (state == LOAD && xfer_done) instruction <= instr_t'(readdata);
    if (state == MEM && ctrl.mem_read && xfer_done) load_data <= readdata;
  end

endmodule

// File: instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
  input  isa_pkg::instr_t instruction,
  output cpu_pkg::ctrl_t  ctrl,
  output isa_pkg::word_t  imm
);
  import isa_pkg::*;
  import cpu_pkg::*;

  logic [15:0] imm16;

  assign imm16 = instruction[15:0];

  // logical immediates are zero extended, everything else sign extended
  assign imm = ctrl.imm_zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

  always_comb begin
    ctrl        = '0; // unknown encodings fall out as a nop
    ctrl.alu_op = ALU_ADD;
    case (instruction.op)
      OP_SPECIAL: begin
        ctrl.dest_is_rd = 1'b1;
        ctrl.reg_write  = 1'b1;
        case (instruction.funct)
          FN_SLL:  ctrl.alu_op = ALU_SLL;
          FN_SRL:  ctrl.alu_op = ALU_SRL;
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLTU: ctrl.alu_op = ALU_SLTU;
          FN_JR: begin
            ctrl.jump_reg  = 1'b1;
            ctrl.reg_write = 1'b0; // no link
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_J:   ctrl.jump = 1'b1;
      OP_BEQ: ctrl.branch = 1'b1; // alu unused, compare is rs == rt
      OP_BNE: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = 1'b1;
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_write   = 1'b1; // rt is the destination
        case (instruction.op)
          OP_SLTI: ctrl.alu_op = ALU_SLT;
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          OP_XORI: ctrl.alu_op = ALU_XOR;
          OP_LUI:  ctrl.alu_op = ALU_LUI;
          default: ctrl.alu_op = ALU_ADD;
        endcase
        ctrl.imm_zero_ext = (instruction.op == OP_ANDI) | (instruction.op == OP_ORI) |
                            (instruction.op == OP_XORI);
      end
      OP_LW: begin
        ctrl.alu_src_imm = 1'b1; // base + offset
        ctrl.mem_read    = 1'b1;
        ctrl.mem_to_reg  = 1'b1;
        ctrl.reg_write   = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      default: ctrl.alu_op = ALU_ADD;
    endcase
  end

endmodule

// File: isa_pkg.sv
package isa_pkg;

  // basic datapath types
  typedef logic [31:0] word_t;    // one bus / register word
  typedef logic [4:0]  reg_idx_t; // gpr index

  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, // r-type, see funct
    OP_J       = 6'h02,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_ANDI    = 6'h0C, // zero-extended imm
    OP_ORI     = 6'h0D, // zero-extended imm
    OP_XORI    = 6'h0E, // zero-extended imm
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } op_t;

  // function code for OP_SPECIAL, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00, // all-zero word is sll $0,$0,0 i.e. nop
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A,
    FN_SLTU = 6'h2B
  } funct_t;

  // r-type field view of an instruction word
  // imm16 is [15:0] and the jump index is [25:0] of the same word
  typedef struct packed {
    op_t        op;    // 31:26
    reg_idx_t   rs;    // 25:21
    reg_idx_t   rt;    // 20:16
    reg_idx_t   rd;    // 15:11
    logic [4:0] shamt; // 10:6
    funct_t     funct; // 5:0
  } instr_t;

endpackage

// File: mips_cpu_bus.sv
`timescale 1ns/100ps

module mips_cpu_bus #(
  parameter logic [31:0] RESET_VECTOR = cpu_pkg::RESET_VECTOR
) (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         active,
  output isa_pkg::word_t               register_v0,

  // avalon-mm master
  output isa_pkg::word_t               address,
  output logic                         write,
  output logic                         read,
  input  logic                         waitrequest,
  output isa_pkg::word_t               writedata,
  output logic [cpu_pkg::BE_W-1:0]     byteenable,
  input  isa_pkg::word_t               readdata
);
  import isa_pkg::*;
  import cpu_pkg::*;

  state_t state;       // current phase of the instruction
  instr_t instruction; // ir contents
  ctrl_t  ctrl;
  word_t  imm;         // sign or zero extended imm16
  word_t  load_data;   // lw result held for exec
  word_t  rs_data, rt_data;
  word_t  alu_result;
  logic   equal;       // rs == rt, for beq/bne
  word_t  pc;

  assign writedata  = rt_data;   // sw always stores rt
  assign byteenable = '1;        // word accesses only

  cpu_sequencer u_seq (
    .clk, .reset, .waitrequest, .readdata,
    .pc, .alu_result, .ctrl,
    .state, .instruction, .load_data,
    .address, .read, .write, .active
  );

  instr_decoder u_dec (
    .instruction,
    .ctrl,
    .imm
  );

  register_file u_rf (
    .clk, .reset, .state, .instruction, .ctrl,
    .alu_result, .load_data,
    .rs_data, .rt_data, .register_v0
  );

  alu u_alu (
    .ctrl, .instruction,
    .rs_data, .rt_data, .imm,
    .alu_result, .equal
  );

  pc_unit #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_pc (
    .clk, .reset, .state, .instruction, .ctrl,
    .rs_data, .imm, .equal,
    .pc
  );

endmodule

// File: pc_unit.sv
`timescale 1ns/100ps

module pc_unit #(
  parameter logic [31:0] RESET_VECTOR = cpu_pkg::RESET_VECTOR
) (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::state_t state,
  input  isa_pkg::instr_t instruction,
  input  cpu_pkg::ctrl_t  ctrl,
  input  isa_pkg::word_t  rs_data,
  input  isa_pkg::word_t  imm,
  input  logic            equal,
  output isa_pkg::word_t  pc
);
  import isa_pkg::*;
  import cpu_pkg::*;

  word_t pc_plus4;
  word_t branch_target;
  word_t jump_target;
  word_t new_target; // target of the instruction in exec
  word_t target_q;   // held over the delay slot
  logic  delay;      // current instruction is a delay slot
  logic  br_taken;
  logic  redirect;   // next instruction is a delay slot

  assign pc_plus4 = pc + 32'd4;

  // relative to the delay slot address
  assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instruction[25:0], 2'b00};

  // beq on equal, bne on not equal
  assign br_taken = ctrl.branch & (equal ^ ctrl.branch_ne);
  assign redirect = br_taken | ctrl.jump | ctrl.jump_reg;

  always_comb begin
    if (ctrl.jump_reg)  new_target = rs_data;
    else if (ctrl.jump) new_target = jump_target;
    else                new_target = branch_target;
  end

  // pc and delay flag
  always_ff @(posedge clk) begin
    if (reset) begin
      pc    <= RESET_VECTOR;
      delay <= 1'b0;
    end else if (state == EXEC) begin
      pc    <= delay ? target_q : pc_plus4; // slot done, go to the held target
      delay <= redirect;
    end
  end

  // target holder, written only when a redirect is pending
  always_ff @(posedge clk) begin
    if (state == EXEC && redirect) target_q <= new_target;
  end

endmodule

// File: register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::state_t state,
  input  isa_pkg::instr_t instruction,
  input  cpu_pkg::ctrl_t  ctrl,
  input  isa_pkg::word_t  alu_result,
  input  isa_pkg::word_t  load_data,
  output isa_pkg::word_t  rs_data,
  output isa_pkg::word_t  rt_data,
  output isa_pkg::word_t  register_v0
);
  import isa_pkg::*;
  import cpu_pkg::*;

  word_t    regs [32];
  reg_idx_t wr_idx;  // destination register
  word_t    wr_data;

  assign wr_idx  = ctrl.dest_is_rd ? instruction.rd : instruction.rt;
  assign wr_data = ctrl.mem_to_reg ? load_data : alu_result;

  // async reads, $zero forced
  assign rs_data = (instruction.rs == '0) ? '0 : regs[instruction.rs];
  assign rt_data = (instruction.rt == '0) ? '0 : regs[instruction.rt];

  assign register_v0 = regs[2]; // $v0 tap for the top level port

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (state == EXEC && ctrl.reg_write && wr_idx != '0) begin
      regs[wr_idx] <= wr_data; // single write port, exec only
    end
  end

endmodule

// File: tb.f
isa_pkg.sv
cpu_pkg.sv
cpu_sequencer.sv
instr_decoder.sv
register_file.sv
alu.sv
pc_unit.sv
mips_cpu_bus.sv
tb_mips_cpu_bus_sva.sv
tb_mips_cpu_bus.sv

// File: tb_mips_cpu_bus.sv
`timescale 1ns/100ps

module tb_mips_cpu_bus;
  import isa_pkg::*;

  localparam word_t PROG_BASE  = 32'hBFC0_0000;
  localparam word_t DATA_BASE  = 32'h0000_1000;
  localparam int    PROG_WORDS = 32;
  localparam int    DATA_WORDS = 16;
  localparam int    N_WAITS    = 256; // pre-drawn wait state counts
  localparam int    HALT_LIMIT = 2000;

  // expected results, worked by hand from the program below
  // t0 = 12345678, t1 = f0f000ff, t0+t1 = 03245777, t0-t1 = 21445579
  // xor -> 2260020e, slt(t1,t0) << 4 = 10 -> 2260021e (stored, then loaded back)
  // path adds 100 + 20 + 3 + 400 + 8 + 40 -> 22600789
  localparam word_t EXP_STORE = 32'h2260_021E;
  localparam word_t EXP_V0    = 32'h2260_0789;

  // mips encodings
  localparam logic [5:0] OPC_R = 6'h00, OPC_J = 6'h02, OPC_BEQ = 6'h04, OPC_BNE = 6'h05;
  localparam logic [5:0] OPC_ADDIU = 6'h09, OPC_ORI = 6'h0D, OPC_LUI = 6'h0F;
  localparam logic [5:0] OPC_LW = 6'h23, OPC_SW = 6'h2B;
  localparam logic [5:0] FUN_SLL = 6'h00, FUN_JR = 6'h08, FUN_ADDU = 6'h21;
  localparam logic [5:0] FUN_SUBU = 6'h23, FUN_XOR = 6'h26, FUN_SLT = 6'h2A;
  localparam logic [4:0] ZERO = 5'd0, V0 = 5'd2, T0 = 5'd8, T1 = 5'd9;
  localparam logic [4:0] T2 = 5'd10, T3 = 5'd11, S0 = 5'd16;

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  logic  waitrequest = 1'b1; // idle slave holds off
  word_t readdata = '0;
  logic  active, read, write;
  word_t register_v0, address, writedata;
  logic [3:0] byteenable;

  word_t       prog_mem [PROG_WORDS];
  word_t       data_mem [DATA_WORDS];
  int unsigned wait_tbl [N_WAITS];
  int unsigned wait_left;
  int unsigned xfer_idx;

  always #4 clk = ~clk;

  mips_cpu_bus #(.RESET_VECTOR(PROG_BASE)) DUT (.*);

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  function automatic word_t asm_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                  logic [4:0] sh, logic [5:0] fn);
    return {OPC_R, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t asm_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t asm_j(logic [5:0] op, word_t target);
    return {op, target[27:2]}; // upper pc bits come from the delay slot address
  endfunction

  task automatic bus_read(input word_t addr, output word_t data);
    if (addr == '0) begin
      data = '0; // nop at address 0, executed just before the halt
    end else if (addr >= PROG_BASE && addr < PROG_BASE + 4 * PROG_WORDS) begin
      data = prog_mem[(addr - PROG_BASE) >> 2];
    end else if (addr >= DATA_BASE && addr < DATA_BASE + 4 * DATA_WORDS) begin
      data = data_mem[(addr - DATA_BASE) >> 2];
    end else begin
      data = ~addr;
      fail_run($sformatf("CPU read from unmapped address %h", addr));
    end
  endtask

  task automatic bus_write(input word_t addr, input word_t data);
    if (addr >= DATA_BASE && addr < DATA_BASE + 4 * DATA_WORDS)
      data_mem[(addr - DATA_BASE) >> 2] = data;
    else
      fail_run($sformatf("CPU wrote to address %h outside the data region", addr));
  endtask

  // avalon slave, registered, so each transfer waits 1 + wait_tbl cycles
  always @(posedge clk) begin : mem_model
    word_t rd_word;
    if (reset) begin
      waitrequest <= 1'b1;
      wait_left   <= wait_tbl[0];
      xfer_idx    <= 0;
    end else if (read || write) begin
      if (!waitrequest) begin // transfer completes at this edge
        if (write) bus_write(address, writedata);
        waitrequest <= 1'b1;
        xfer_idx    <= xfer_idx + 1;
        wait_left   <= wait_tbl[(xfer_idx + 1) % N_WAITS];
      end else if (wait_left == 0) begin
        if (read) begin
          bus_read(address, rd_word);
          readdata <= rd_word;
        end
        waitrequest <= 1'b0;
      end else begin
        wait_left <= wait_left - 1;
      end
    end
  end

  // bound checker failures end the run one cycle later
  always @(posedge clk) begin
    if (DUT.u_sva.error_count != 0) fail_run("a bus protocol assertion failed, see above");
  end

  task automatic load_program();
    for (int i = 0; i < PROG_WORDS; i++) prog_mem[i] = ~(PROG_BASE + 4 * i);
    for (int i = 0; i < DATA_WORDS; i++) data_mem[i] = 32'hDA7A_0000 ^ (DATA_BASE + 4 * i);
    prog_mem[0]  = asm_i(OPC_LUI, ZERO, T0, 16'h1234);
    prog_mem[1]  = asm_i(OPC_ORI, T0, T0, 16'h5678);
    prog_mem[2]  = asm_i(OPC_LUI, ZERO, T1, 16'hF0F0);
    prog_mem[3]  = asm_i(OPC_ORI, T1, T1, 16'h00FF);
    prog_mem[4]  = asm_r(T0, T1, V0, 5'd0, FUN_ADDU);
    prog_mem[5]  = asm_r(T0, T1, T2, 5'd0, FUN_SUBU);
    prog_mem[6]  = asm_r(V0, T2, V0, 5'd0, FUN_XOR);
    prog_mem[7]  = asm_r(T1, T0, T3, 5'd0, FUN_SLT);  // negative < positive
    prog_mem[8]  = asm_r(ZERO, T3, T3, 5'd4, FUN_SLL);
    prog_mem[9]  = asm_r(V0, T3, V0, 5'd0, FUN_ADDU);
    prog_mem[10] = asm_i(OPC_ORI, ZERO, S0, 16'h1000);
    prog_mem[11] = asm_i(OPC_SW, S0, V0, 16'h0000);
    prog_mem[12] = asm_i(OPC_ADDIU, ZERO, V0, 16'h0000); // clear before the load
    prog_mem[13] = asm_i(OPC_LW, S0, V0, 16'h0000);
    prog_mem[14] = asm_i(OPC_BEQ, T0, T0, 16'd2);        // taken, to 17
    prog_mem[15] = asm_i(OPC_ADDIU, V0, V0, 16'h0100);   // delay slot
    prog_mem[16] = asm_i(OPC_ADDIU, V0, V0, 16'h7000);   // skipped
    prog_mem[17] = asm_i(OPC_BNE, T0, T0, 16'd5);        // not taken
    prog_mem[18] = asm_i(OPC_ADDIU, V0, V0, 16'h0020);
    prog_mem[19] = asm_i(OPC_ADDIU, V0, V0, 16'h0003);
    prog_mem[20] = asm_j(OPC_J, PROG_BASE + 4 * 23);
    prog_mem[21] = asm_i(OPC_ADDIU, V0, V0, 16'h0400);   // delay slot
    prog_mem[22] = asm_i(OPC_ADDIU, V0, V0, 16'h5000);   // skipped
    prog_mem[23] = asm_i(OPC_ADDIU, V0, V0, 16'h0008);
    prog_mem[24] = asm_r(ZERO, ZERO, ZERO, 5'd0, FUN_JR); // jr $zero
    prog_mem[25] = asm_i(OPC_ADDIU, V0, V0, 16'h0040);   // delay slot before the halt
  endtask

  initial begin
    int unsigned cycles;
    void'($urandom(25));
    for (int i = 0; i < N_WAITS; i++) wait_tbl[i] = $urandom % 4;
    load_program();
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    cycles = 0;
    while (active && cycles < HALT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (active) fail_run($sformatf("timeout, CPU never halted within %0d cycles", HALT_LIMIT));
    repeat (5) @(posedge clk); // let the checker watch the idle bus
    @(negedge clk); // mid cycle, everything from the last edge has settled

    a_store: assert (data_mem[0] == EXP_STORE)
      else fail_run($sformatf("** Error at %0t: word at 1000 is %h, expected %h",
                              $time, data_mem[0], EXP_STORE));
    a_v0: assert (register_v0 == EXP_V0)
      else fail_run($sformatf("** Error at %0t: register_v0 is %h, expected %h",
                              $time, register_v0, EXP_V0));

    if (DUT.u_sva.error_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run("a bus protocol assertion failed, see above");
    end
  end

endmodule

// File: tb_mips_cpu_bus_sva.sv
`timescale 1ns/100ps

module tb_mips_cpu_bus_sva (
  input logic                     clk,
  input logic                     reset,
  input logic                     active,
  input isa_pkg::word_t           address,
  input logic                     read,
  input logic                     write,
  input logic                     waitrequest,
  input isa_pkg::word_t           writedata,
  input logic [cpu_pkg::BE_W-1:0] byteenable
);

  int unsigned error_count = 0; // polled by the testbench top

  // first cycle with reset low is the idle fetch cycle
  a_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> active && !read && !write)
    else begin
      $error("bus not idle or cpu not active in the first cycle after reset");
      error_count++;
    end

  a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(read && write))
    else begin
      $error("read and write asserted together");
      error_count++;
    end

  // a stalled read keeps its request until the slave drops waitrequest
  a_read_hold: assert property (@(posedge clk) disable iff (reset)
    read && waitrequest |=> read && $stable(address))
    else begin
      $error("read request changed while waitrequest was high");
      error_count++;
    end

  a_write_hold: assert property (@(posedge clk) disable iff (reset)
    write && waitrequest |=> write && $stable(address) && $stable(writedata))
    else begin
      $error("write request changed while waitrequest was high");
      error_count++;
    end

  a_aligned: assert property (@(posedge clk) disable iff (reset)
    (read || write) |-> address[1:0] == 2'b00)
    else begin
      $error("transfer address not word aligned");
      error_count++;
    end

  a_full_word: assert property (@(posedge clk) disable iff (reset) write |-> &byteenable)
    else begin
      $error("byteenable not all ones during a write");
      error_count++;
    end

  // once halted the master stays off the bus until reset
  a_halted_idle: assert property (@(posedge clk) disable iff (reset)
    !active |-> !read && !write ##1 !active)
    else begin
      $error("bus activity or restart after the cpu halted");
      error_count++;
    end

endmodule

bind mips_cpu_bus tb_mips_cpu_bus_sva u_sva (
  .clk(clk),
  .reset(reset),
  .active(active),
  .address(address),
  .read(read),
  .write(write),
  .waitrequest(waitrequest),
  .writedata(writedata),
  .byteenable(byteenable)
);
